// File: Makefile
# Verilator build and run of the GHT testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module ghtTb -Mdir obj_dir -o simGht
	./obj_dir/simGht | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
verilog/ghtAddrPkg.sv
verilog/ghtCounterPkg.sv
verilog/ghtInitSeq.sv
verilog/ghtWriteArbiter.sv
verilog/ghtBank.sv
verilog/ghtReadPath.sv
verilog/ghtTop.sv
verification/ght_properties.sv
verification/ghtTb.sv

// File: verification/ghtTb.sv
/*
 * GHT testbench
 * Runs the operations of the test file against the table, then a
 * random write and lookup phase checked against a model of the table.
 */
`timescale 1ns/100ps

module ghtTb import ghtAddrPkg::*; import ghtCounterPkg::*; ();

    localparam int FIELDS = 7;
    localparam int MAX_TESTS = 64;
    localparam int RESET_CYCLES = 2;

    logic clk;
    logic rst;
    logic readEn;
    ipBits_t ip;
    ghtHist_t hist;
    logic wrEn0;
    tableAddr_t wrAddr0;
    ctr_t wrCtr0;
    logic wrEn1;
    tableAddr_t wrAddr1;
    ctr_t wrCtr1;
    ctr_t predCtr;
    logic predValid;
    logic tableReady;

    logic [31:0] testWords [0:FIELDS*MAX_TESTS-1];
    // expected counters, indexed by hashed table address
    ctr_t model [0:65535];
    int errCount = 0;
    int checkCount = 0;
    int testNum = 0;
    int cycleCount = 0;
    int cycleLimit = 64;

    ghtTop #(.numRows(NUM_ROWS)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    task automatic applyWrite(input logic en0, input tableAddr_t addr0, input ctr_t ctr0,
            input logic en1, input tableAddr_t addr1, input ctr_t ctr1);
        @(posedge clk);
        wrEn0 <= en0;
        wrAddr0 <= addr0;
        wrCtr0 <= ctr0;
        wrEn1 <= en1;
        wrAddr1 <= addr1;
        wrCtr1 <= ctr1;
        @(posedge clk);
        wrEn0 <= 1'b0;
        wrEn1 <= 1'b0;
        // a saved port 1 write lands after port 0
        if (en0) begin
            model[addr0] = ctr0;
        end
        if (en1) begin
            model[addr1] = ctr1;
        end
    endtask

    task automatic checkLookup(input ipBits_t lookIp, input ghtHist_t lookHist,
            input ctr_t expCtr);
        int errBefore;
        errBefore = errCount;
        @(posedge clk);
        readEn <= 1'b1;
        ip <= lookIp;
        hist <= lookHist;
        @(posedge clk);
        readEn <= 1'b0;
        @(negedge clk);
        checkCount += 2;
        assert (predValid === 1'b1) else begin
            $display("ERR %0t: predValid expected 1 got %b", $time, predValid);
            errCount++;
        end
        assert (predCtr === expCtr) else begin
            $display("ERR %0t: ip %h hist %h counter expected %0d got %0d",
                $time, lookIp, lookHist, expCtr, predCtr);
            errCount++;
        end
        testNum++;
        $display("test %0d: lookup ip %h hist %h expected %0d got %0d %s", testNum,
            lookIp, lookHist, expCtr, predCtr, (errCount == errBefore) ? "ok" : "bad");
    endtask

    task automatic runRandom(input int count);
        logic [31:0] rnd;
        tableAddr_t addr;
        tableAddr_t lookAddr;
        ipBits_t lookIp;
        ghtHist_t lookHist;
        for (int i = 0; i < count; i++) begin
            rnd = $urandom;
            addr = rnd[15:0];
            // single port per write, then an idle cycle
            if (rnd[18]) begin
                applyWrite(1'b0, '0, '0, 1'b1, addr, rnd[17:16]);
            end else begin
                applyWrite(1'b1, addr, rnd[17:16], 1'b0, '0, '0);
            end
            @(posedge clk);
            rnd = $urandom;
            lookHist = rnd[7:0];
            // half of the lookups hit the address just written
            if (rnd[8]) begin
                lookAddr = addr;
            end else begin
                lookAddr = rnd[31:16];
            end
            // ip picked so the history hash lands on lookAddr
            lookIp = {lookAddr[15:8] ^ lookHist, lookAddr[7:0]};
            checkLookup(lookIp, lookHist, model[lookAddr]);
        end
    endtask

    initial begin
        int numTests;
        int weight;
        int base;
        rst = 1'b1;
        readEn = 1'b0;
        ip = '0;
        hist = '0;
        wrEn0 = 1'b0;
        wrAddr0 = '0;
        wrCtr0 = '0;
        wrEn1 = 1'b0;
        wrAddr1 = '0;
        wrCtr1 = '0;
        void'($urandom(32'hadf3_b0a3));
        foreach (model[a]) begin
            model[a] = '0;
        end
        $readmemh("verification/ght_tests.txt", testWords);
        numTests = 0;
        weight = 0;
        while (numTests < MAX_TESTS && testWords[numTests * FIELDS] != 32'h0) begin
            base = numTests * FIELDS;
            weight += 1;
            if (testWords[base] == 32'h3) begin
                weight += int'(testWords[base + 1]);
            end else if (testWords[base] == 32'h4) begin
                weight += 2 * int'(testWords[base + 1]);
            end
            numTests++;
        end
        cycleLimit = weight * 4 + 64;
        if (numTests == 0) begin
            $display("no tests could be read from the test file");
            errCount++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (!tableReady) begin
            @(negedge clk);
        end
        $display("table ready at cycle %0d", cycleCount);
        // one row cleared per cycle once reset is released
        checkCount++;
        assert (cycleCount == RESET_CYCLES + NUM_ROWS) else begin
            $display("ERR %0t: tableReady expected at cycle %0d got cycle %0d",
                $time, RESET_CYCLES + NUM_ROWS, cycleCount);
            errCount++;
        end
        for (int t = 0; t < numTests; t++) begin
            base = t * FIELDS;
            case (testWords[base])
                32'h1: begin
                    applyWrite(testWords[base + 1][0], testWords[base + 2][15:0],
                        testWords[base + 3][1:0], testWords[base + 4][0],
                        testWords[base + 5][15:0], testWords[base + 6][1:0]);
                    testNum++;
                    $display("test %0d: write en0 %0d addr %h ctr %0d, en1 %0d addr %h ctr %0d",
                        testNum, testWords[base + 1][0], testWords[base + 2][15:0],
                        testWords[base + 3][1:0], testWords[base + 4][0],
                        testWords[base + 5][15:0], testWords[base + 6][1:0]);
                end
                32'h2: begin
                    checkLookup(testWords[base + 1][15:0], testWords[base + 2][7:0],
                        testWords[base + 3][1:0]);
                end
                32'h3: begin
                    repeat (testWords[base + 1]) @(posedge clk);
                    testNum++;
                    $display("test %0d: idle %0d cycles", testNum, testWords[base + 1]);
                end
                32'h4: begin
                    runRandom(int'(testWords[base + 1]));
                end
                default: begin
                    $display("unknown operation %h on test line %0d", testWords[base], t + 1);
                    errCount++;
                end
            endcase
        end
        $display("tests %0d, checks %0d, errors %0d", testNum, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verification/ght_properties.sv
/*
 * GHT properties
 * Output levels after reset and a table-ready that never drops.
 */
`timescale 1ns/100ps

module ghtProperties (
    input logic clk,
    input logic rst,
    input logic predValid,
    input logic tableReady
);

    // both levels come out of reset low
    predValidAfterReset: assert property (@(posedge clk) rst |=> !predValid)
        else $error("predValid high in the cycle after reset");

    tableReadyAfterReset: assert property (@(posedge clk) rst |=> !tableReady)
        else $error("tableReady high in the cycle after reset");

    // cleared table stays ready until the next reset
    tableReadyHolds: assert property (@(posedge clk) disable iff (rst)
        tableReady |=> tableReady)
        else $error("tableReady fell without a reset");

endmodule

bind ghtTop ghtProperties i_props (
    .clk(clk),
    .rst(rst),
    .predValid(predValid),
    .tableReady(tableReady)
);

// File: verification/ght_tests.txt
// columns: op en0|ip|cycles addr0|hist ctr0|expected en1 addr1 ctr1, all hex
// op 1 write pair, 2 lookup, 3 idle, 4 random writes and lookups, 0 end
3 2 0 0 0 0 0
2 1234 00 0 0 0 0
2 ffff 5a 0 0 0 0
2 0000 00 0 0 0 0
2 c3ab 3c 0 0 0 0
1 1 3c42 3 0 0000 0
2 3c42 00 3 0 0 0
1 1 1080 2 1 1041 1
2 1080 00 2 0 0 0
2 1041 00 1 0 0 0
1 1 9b81 2 1 9bc1 3
2 9b81 00 2 0 0 0
2 9bc1 00 3 0 0 0
1 1 2004 1 1 7710 3
3 1 0 0 0 0 0
2 2004 00 1 0 0 0
2 7710 00 3 0 0 0
1 1 5a06 2 0 0000 0
2 0006 5a 2 0 0 0
2 0006 00 0 0 0 0
2 ff06 a5 2 0 0 0
1 0 0000 0 1 c3ab 1
2 c3ab 00 1 0 0 0
2 3cab ff 1 0 0 0
1 1 3c42 1 0 0000 0
2 3c42 00 1 0 0 0
4 40 0 0 0 0 0
0 0 0 0 0 0 0

// File: verilog/ghtAddrPkg.sv
/*
 * GHT address package
 * Lookup and table address widths, table geometry and the
 * field rules that split a table address into bank, row and column.
 */
package ghtAddrPkg;

    localparam int NUM_BANKS = 8;
    localparam int NUM_ROWS = 32;
    localparam int NUM_COLS = 256;

    typedef logic [15:0] ipBits_t;
    typedef logic [7:0] ghtHist_t;
    typedef logic [15:0] tableAddr_t;
    typedef logic [2:0] bankIdx_t;
    typedef logic [4:0] rowIdx_t;
    typedef logic [7:0] colIdx_t;

    // bank bits are scattered: 7 and 6 on top, 0 at the bottom
    function automatic bankIdx_t bankOf(input tableAddr_t addr);
        return {addr[7], addr[6], addr[0]};
    endfunction

    function automatic rowIdx_t rowOf(input tableAddr_t addr);
        return addr[5:1];
    endfunction

    function automatic colIdx_t colOf(input tableAddr_t addr);
        return addr[15:8];
    endfunction

endpackage

// File: verilog/ghtBank.sv
/*
 * GHT bank
 * Row storage of one bank with a per-counter bit-enabled write,
 * whole-row clear during init and a combinational counter read.
 */
`timescale 1ns/100ps

module ghtBank import ghtAddrPkg::*; import ghtCounterPkg::*; #(
    parameter int bankIndex = 0,
    parameter int numRows = 32
) (
    input  logic    clk,
    input  logic    initBusy,
    input  rowIdx_t initRow,
    input  logic    wen,
    input  rowIdx_t wrRow,
    input  colIdx_t wrCol,
    input  ctr_t    wrCtr,
    input  rowIdx_t rdRow,
    input  colIdx_t rdCol,
    output ctr_t    rdCtr
);

    localparam int rowBits = (numRows > 1) ? $clog2(numRows) : 1;

    // elaboration check of the bank geometry
    if (bankIndex >= NUM_BANKS || numRows > NUM_ROWS || numRows < 2 ||
            (numRows & (numRows - 1)) != 0) begin : paramCheck
        $error("ghtBank %0d: unsupported row count %0d", bankIndex, numRows);
    end

    rowWord_t mem [numRows];

    rowWord_t bitEn;
    rowWord_t wrData;
    rowWord_t rdWord;
    logic [rowBits-1:0] wrIdx;

    assign wrIdx = initBusy ? initRow[rowBits-1:0] : wrRow[rowBits-1:0];

    always_comb begin
        bitEn = '0;
        wrData = '0;
        if (initBusy) begin
            // data stays zero, whole row enabled
            bitEn = '1;
        end else if (wen) begin
            bitEn[{wrCol, 1'b0} +: 2] = 2'b11;
            wrData[{wrCol, 1'b0} +: 2] = wrCtr;
        end
    end

    always_ff @(posedge clk) begin
        if (initBusy || wen) begin
            mem[wrIdx] <= (mem[wrIdx] & ~bitEn) | (wrData & bitEn);
        end
    end

    assign rdWord = mem[rdRow[rowBits-1:0]];
    assign rdCtr = rdWord[{rdCol, 1'b0} +: 2];

endmodule

// File: verilog/ghtCounterPkg.sv
/*
 * GHT counter package
 * Counter and row word types plus the init sequencer states.
 */
package ghtCounterPkg;

    // 256 counters of 2 bits each
    localparam int ROW_BITS = 512;

    // saturating counter, upper bit set means taken
    typedef logic [1:0] ctr_t;

    typedef logic [ROW_BITS-1:0] rowWord_t;

    typedef enum logic {
        initClear,
        initDone
    } initState_t;

endpackage

// File: verilog/ghtInitSeq.sv
/*
 * GHT init sequencer
 * Walks every row once after reset so the banks zero it,
 * then holds the table ready.
 */
`timescale 1ns/100ps

module ghtInitSeq import ghtAddrPkg::*; import ghtCounterPkg::*; #(
    parameter int numRows = 32
) (
    input  logic    clk,
    input  logic    rst,
    output logic    initBusy,
    output rowIdx_t initRow,
    output logic    tableReady
);

    initState_t state;
    rowIdx_t rowCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= initClear;
            rowCnt <= '0;
        end else if (state == initClear) begin
            rowCnt <= rowCnt + 1'b1;
            // last row cleared at this edge
            if (rowCnt == rowIdx_t'(numRows - 1)) begin
                state <= initDone;
            end
        end
    end

    assign initBusy = (state == initClear);
    assign tableReady = (state == initDone);
    assign initRow = rowCnt;

endmodule

// File: verilog/ghtReadPath.sv
/*
 * GHT read path
 * Registers the lookup inputs, hashes history into the upper address
 * byte and picks the counter from the addressed bank.
 */
`timescale 1ns/100ps

module ghtReadPath import ghtAddrPkg::*; import ghtCounterPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  readEn,
    input  ipBits_t               ip,
    input  ghtHist_t              hist,
    input  ctr_t [NUM_BANKS-1:0]  bankRdCtr,
    output rowIdx_t               rdRow,
    output colIdx_t               rdCol,
    output ctr_t                  predCtr,
    output logic                  predValid
);

    ipBits_t ipReg;
    ghtHist_t histReg;
    tableAddr_t rdAddr;

    always_ff @(posedge clk) begin
        if (readEn) begin
            ipReg <= ip;
            histReg <= hist;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else if (readEn) begin
            predValid <= 1'b1;
        end
    end

    // history folds into the column byte only
    assign rdAddr = {ipReg[15:8] ^ histReg, ipReg[7:0]};

    assign rdRow = rowOf(rdAddr);
    assign rdCol = colOf(rdAddr);

    // every bank reads the same row and column, the bank bits choose
    assign predCtr = bankRdCtr[bankOf(rdAddr)];

endmodule

// File: verilog/ghtTop.sv
/*
 * GHT top level
 * Eight-bank global history table with init clear, two update
 * ports and a single registered lookup.
 */
`timescale 1ns/100ps

module ghtTop import ghtAddrPkg::*; import ghtCounterPkg::*; #(
    parameter int numRows = NUM_ROWS
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       readEn,
    input  ipBits_t    ip,
    input  ghtHist_t   hist,
    input  logic       wrEn0,
    input  tableAddr_t wrAddr0,
    input  ctr_t       wrCtr0,
    input  logic       wrEn1,
    input  tableAddr_t wrAddr1,
    input  ctr_t       wrCtr1,
    output ctr_t       predCtr,
    output logic       predValid,
    output logic       tableReady
);

    logic initBusy;
    rowIdx_t initRow;

    logic [NUM_BANKS-1:0] bankWen;
    rowIdx_t [NUM_BANKS-1:0] bankRow;
    colIdx_t [NUM_BANKS-1:0] bankCol;
    ctr_t [NUM_BANKS-1:0] bankCtr;
    ctr_t [NUM_BANKS-1:0] bankRdCtr;

    rowIdx_t rdRow;
    colIdx_t rdCol;

    ghtInitSeq #(
        .numRows(numRows)
    ) i_initSeq (
        .clk(clk),
        .rst(rst),
        .initBusy(initBusy),
        .initRow(initRow),
        .tableReady(tableReady)
    );

    ghtWriteArbiter i_writeArbiter (
        .clk(clk),
        .rst(rst),
        .initBusy(initBusy),
        .wrEn0(wrEn0),
        .wrAddr0(wrAddr0),
        .wrCtr0(wrCtr0),
        .wrEn1(wrEn1),
        .wrAddr1(wrAddr1),
        .wrCtr1(wrCtr1),
        .bankWen(bankWen),
        .bankRow(bankRow),
        .bankCol(bankCol),
        .bankCtr(bankCtr)
    );

    for (genvar k = 0; k < NUM_BANKS; k++) begin : banks
        ghtBank #(
            .bankIndex(k),
            .numRows(numRows)
        ) i_bank (
            .clk(clk),
            .initBusy(initBusy),
            .initRow(initRow),
            .wen(bankWen[k]),
            .wrRow(bankRow[k]),
            .wrCol(bankCol[k]),
            .wrCtr(bankCtr[k]),
            .rdRow(rdRow),
            .rdCol(rdCol),
            .rdCtr(bankRdCtr[k])
        );
    end

    ghtReadPath i_readPath (
        .clk(clk),
        .rst(rst),
        .readEn(readEn),
        .ip(ip),
        .hist(hist),
        .bankRdCtr(bankRdCtr),
        .rdRow(rdRow),
        .rdCol(rdCol),
        .predCtr(predCtr),
        .predValid(predValid)
    );

endmodule

// File: verilog/ghtWriteArbiter.sv
/*
 * GHT write arbiter
 * Steers two update ports onto the eight banks, one write per bank
 * per cycle, parking a conflicting update in a one-entry save buffer.
 */
`timescale 1ns/100ps

module ghtWriteArbiter import ghtAddrPkg::*; import ghtCounterPkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     initBusy,
    input  logic                     wrEn0,
    input  tableAddr_t               wrAddr0,
    input  ctr_t                     wrCtr0,
    input  logic                     wrEn1,
    input  tableAddr_t               wrAddr1,
    input  ctr_t                     wrCtr1,
    output logic [NUM_BANKS-1:0]     bankWen,
    output rowIdx_t [NUM_BANKS-1:0]  bankRow,
    output colIdx_t [NUM_BANKS-1:0]  bankCol,
    output ctr_t [NUM_BANKS-1:0]     bankCtr
);

    logic savedPend;
    tableAddr_t savedAddr;
    ctr_t savedCtr;

    bankIdx_t bank0;
    bankIdx_t bank1;
    bankIdx_t savedBank;
    logic live0;
    logic live1;
    logic take1;
    logic save0;
    logic save1;

    assign bank0 = bankOf(wrAddr0);
    assign bank1 = bankOf(wrAddr1);
    assign savedBank = bankOf(savedAddr);

    // ports are ignored while the table is being cleared
    assign live0 = wrEn0 && !initBusy;
    assign live1 = wrEn1 && !initBusy;

    assign take1 = live1 && !(live0 && bank1 == bank0);

    assign save1 = savedPend ?
        live1 && !(live0 && bank0 == savedBank) &&
            (bank1 == savedBank || (live0 && bank1 == bank0)) :
        live1 && live0 && bank1 == bank0;
    assign save0 = savedPend && live0 && bank0 == savedBank && !save1;

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (savedPend) begin
                // saved write owns the cycle
                bankWen[b] = (savedBank == bankIdx_t'(b));
                bankRow[b] = rowOf(savedAddr);
                bankCol[b] = colOf(savedAddr);
                bankCtr[b] = savedCtr;
            end else if (live0 && bank0 == bankIdx_t'(b)) begin
                bankWen[b] = 1'b1;
                bankRow[b] = rowOf(wrAddr0);
                bankCol[b] = colOf(wrAddr0);
                bankCtr[b] = wrCtr0;
            end else begin
                bankWen[b] = take1 && bank1 == bankIdx_t'(b);
                bankRow[b] = rowOf(wrAddr1);
                bankCol[b] = colOf(wrAddr1);
                bankCtr[b] = wrCtr1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            savedPend <= 1'b0;
        end else begin
            savedPend <= save0 || save1;
        end
    end

    always_ff @(posedge clk) begin
        if (save1) begin
            savedAddr <= wrAddr1;
            savedCtr <= wrCtr1;
        end else if (save0) begin
            savedAddr <= wrAddr0;
            savedCtr <= wrCtr0;
        end
    end

endmodule
